/* hdl/aes_cfg_pkg.sv */
package aes_cfg_pkg;

  // Memory byte address width, shared by both ports
  localparam int ADDR_WIDTH = 32;

  // APB register offsets
  localparam logic [7:0] REG_CTRL   = 8'h00;
  localparam logic [7:0] REG_STATUS = 8'h04;
  localparam logic [7:0] REG_SRC    = 8'h08;
  localparam logic [7:0] REG_DST    = 8'h0C;
  localparam logic [7:0] REG_LEN    = 8'h10;
  localparam logic [7:0] REG_KEY    = 8'h14;

  // Bit positions inside the STATUS word
  localparam int STATUS_BUSY = 0;
  localparam int STATUS_DONE = 1;

endpackage

/* hdl/aes_data_pkg.sv */
package aes_data_pkg;

  // Byte view, byte 3 is the most significant
  typedef struct packed {
    logic [7:0] b3;
    logic [7:0] b2;
    logic [7:0] b1;
    logic [7:0] b0;
  } aes_bytes_t;

  // One cipher word, seen whole or byte by byte
  typedef union packed {
    logic [31:0] word;
    aes_bytes_t  bytes;
  } aes_word_u;

  // Left rotation of the whole word after key mixing
  localparam int WORD_ROTATE = 8;

endpackage

/* hdl/aes_regfile.sv */
module aes_regfile (
  input  logic                                 clk,
  input  logic                                 reset_n,
  input  logic                                 psel_i,
  input  logic                                 penable_i,
  input  logic                                 pwrite_i,
  input  logic [7:0]                           paddr_i,
  input  logic [31:0]                          pwdata_i,
  input  logic                                 busy_i,
  input  logic                                 done_i,
  output logic [31:0]                          prdata_o,
  output logic                                 pslverr_o,
  output logic                                 start_o,
  output logic [aes_cfg_pkg::ADDR_WIDTH-1:0]   src_base_o,
  output logic [aes_cfg_pkg::ADDR_WIDTH-1:0]   dst_base_o,
  output logic [15:0]                          length_o,
  output aes_data_pkg::aes_word_u              key_o
);

  logic [aes_cfg_pkg::ADDR_WIDTH-1:0] src_base_q;
  logic [aes_cfg_pkg::ADDR_WIDTH-1:0] dst_base_q;
  logic [15:0]                        length_q;
  aes_data_pkg::aes_word_u            key_q;
  logic                               start_q;
  logic                               done_q;
  logic                               access;
  logic                               addr_valid;
  logic                               busy_err;
  logic                               write_ok;

  // Access phase completes in the same cycle
  assign access = psel_i & penable_i;

  // Address decode and read mux
  always_comb begin
    addr_valid = 1'b1;
    busy_err   = 1'b0;
    prdata_o   = '0;
    case (paddr_i)
      aes_cfg_pkg::REG_CTRL: begin
        prdata_o = '0;
      end
      aes_cfg_pkg::REG_STATUS: begin
        prdata_o[aes_cfg_pkg::STATUS_BUSY] = busy_i;
        prdata_o[aes_cfg_pkg::STATUS_DONE] = done_q;
      end
      aes_cfg_pkg::REG_SRC: begin
        prdata_o = src_base_q;
        busy_err = pwrite_i & busy_i;
      end
      aes_cfg_pkg::REG_DST: begin
        prdata_o = dst_base_q;
        busy_err = pwrite_i & busy_i;
      end
      aes_cfg_pkg::REG_LEN: begin
        prdata_o = {16'h0000, length_q};
        busy_err = pwrite_i & busy_i;
      end
      aes_cfg_pkg::REG_KEY: begin
        prdata_o = key_q.word;
        busy_err = pwrite_i & busy_i;
      end
      default: begin
        addr_valid = 1'b0;
      end
    endcase
  end

  assign pslverr_o = access & (~addr_valid | busy_err);
  assign write_ok  = access & pwrite_i & addr_valid & ~busy_err;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      src_base_q <= '0;
      dst_base_q <= '0;
      length_q   <= '0;
      key_q      <= '0;
      start_q    <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      // One-cycle trigger from CTRL bit 0
      start_q <= write_ok & (paddr_i == aes_cfg_pkg::REG_CTRL) & pwdata_i[0];
      // Sticky done, cleared only by a start the FSM will take
      if (done_i) begin
        done_q <= 1'b1;
      end else if (start_q & ~busy_i) begin
        done_q <= 1'b0;
      end
      if (write_ok) begin
        case (paddr_i)
          aes_cfg_pkg::REG_SRC: src_base_q <= pwdata_i;
          aes_cfg_pkg::REG_DST: dst_base_q <= pwdata_i;
          aes_cfg_pkg::REG_LEN: length_q   <= pwdata_i[15:0];
          aes_cfg_pkg::REG_KEY: key_q.word <= pwdata_i;
          default: ;
        endcase
      end
    end
  end

  assign start_o    = start_q;
  assign src_base_o = src_base_q;
  assign dst_base_o = dst_base_q;
  assign length_o   = length_q;
  assign key_o      = key_q;

  // Access phase must follow a setup phase
  a_apb_setup: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(penable_i) |-> psel_i && $past(psel_i && !penable_i))
    else $error("APB access phase without setup phase");

endmodule

/* hdl/aes_fsm.sv */
module aes_fsm (
  input  logic clk,
  input  logic reset_n,
  input  logic start_i,
  input  logic src_done_i,
  input  logic sink_done_i,
  input  logic fifo_empty_i,
  output logic job_start_o,
  output logic busy_o,
  output logic done_o
);

  localparam logic [1:0] IDLE     = 2'd0;
  localparam logic [1:0] STARTING = 2'd1;
  localparam logic [1:0] WORKING  = 2'd2;
  localparam logic [1:0] FINISHED = 2'd3;

  logic [1:0] state_q;
  logic [1:0] state_d;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      // Start pulses outside IDLE are dropped
      IDLE: begin
        if (start_i) begin
          state_d = STARTING;
        end
      end
      STARTING: begin
        state_d = WORKING;
      end
      // Both streams drained and nothing left in flight
      WORKING: begin
        if (src_done_i && sink_done_i && fifo_empty_i) begin
          state_d = FINISHED;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  assign job_start_o = (state_q == STARTING);
  assign busy_o      = (state_q != IDLE);
  assign done_o      = (state_q == FINISHED);

  a_start_done: assert property (@(posedge clk) disable iff (!reset_n)
    !(job_start_o && done_o))
    else $error("job start and done raised together");

endmodule

/* hdl/plaintext_source.sv */
module plaintext_source (
  input  logic                               clk,
  input  logic                               reset_n,
  input  logic                               job_start_i,
  input  logic [aes_cfg_pkg::ADDR_WIDTH-1:0] base_i,
  input  logic [15:0]                        length_i,
  input  logic                               rd_gnt_i,
  input  logic [31:0]                        rd_data_i,
  input  logic                               rd_valid_i,
  input  logic                               fifo_full_i,
  output logic                               rd_req_o,
  output logic [aes_cfg_pkg::ADDR_WIDTH-1:0] rd_addr_o,
  output logic                               push_o,
  output logic [31:0]                        push_data_o,
  output logic                               done_o
);

  logic [aes_cfg_pkg::ADDR_WIDTH-1:0] addr_q;
  logic [15:0]                        remaining_q;
  logic                               req_q;
  logic                               wait_q;
  logic                               issue;

  // Next request may overlap the return of the current word,
  // fifo_full_i already counts that word
  assign issue = (remaining_q != '0) && !req_q && (!wait_q || rd_valid_i) && !fifo_full_i;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      addr_q      <= '0;
      remaining_q <= '0;
      req_q       <= 1'b0;
      wait_q      <= 1'b0;
    end else if (job_start_i) begin
      addr_q      <= base_i;
      remaining_q <= length_i;
      req_q       <= 1'b0;
      wait_q      <= 1'b0;
    end else begin
      if (req_q && rd_gnt_i) begin
        req_q       <= 1'b0;
        wait_q      <= 1'b1;
        addr_q      <= addr_q + aes_cfg_pkg::ADDR_WIDTH'(4);
        remaining_q <= remaining_q - 16'd1;
      end else if (issue) begin
        req_q <= 1'b1;
      end
      if (wait_q && rd_valid_i) begin
        wait_q <= 1'b0;
      end
    end
  end

  assign rd_req_o    = req_q;
  assign rd_addr_o   = addr_q;
  assign push_o      = wait_q & rd_valid_i;
  assign push_data_o = rd_data_i;
  assign done_o      = (remaining_q == '0) && !req_q && !wait_q;

  a_rd_stable: assert property (@(posedge clk) disable iff (!reset_n)
    rd_req_o && !rd_gnt_i |=> rd_req_o && $stable(rd_addr_o))
    else $error("read request changed before grant");

endmodule

/* hdl/word_fifo.sv */
module word_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        clear_i,
  input  logic        push_i,
  input  logic [31:0] push_data_i,
  input  logic        pop_i,
  output logic [31:0] pop_data_o,
  output logic        full_o,
  output logic        empty_o,
  output logic        almost_full_o
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  logic [31:0]      mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Pointers wrap on their own for a power-of-two depth
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign pop_data_o    = mem_q[rd_ptr_q];
  assign full_o        = (count_q == (PTR_W+1)'(FIFO_DEPTH));
  assign empty_o       = (count_q == '0);
  // One slot or fewer left
  assign almost_full_o = (count_q >= (PTR_W+1)'(FIFO_DEPTH - 1));

  a_no_overflow: assert property (@(posedge clk) disable iff (!reset_n) push_i |-> !full_o)
    else $error("push into full FIFO");
  a_no_underflow: assert property (@(posedge clk) disable iff (!reset_n) pop_i |-> !empty_o)
    else $error("pop from empty FIFO");

endmodule

/* hdl/cipher_sink.sv */
module cipher_sink (
  input  logic                               clk,
  input  logic                               reset_n,
  input  logic                               job_start_i,
  input  logic [aes_cfg_pkg::ADDR_WIDTH-1:0] base_i,
  input  logic [15:0]                        length_i,
  input  aes_data_pkg::aes_word_u            key_i,
  input  logic [31:0]                        pop_data_i,
  input  logic                               fifo_empty_i,
  input  logic                               wr_gnt_i,
  output logic                               pop_o,
  output logic                               wr_req_o,
  output logic [aes_cfg_pkg::ADDR_WIDTH-1:0] wr_addr_o,
  output logic [31:0]                        wr_data_o,
  output logic                               done_o
);

  logic [aes_cfg_pkg::ADDR_WIDTH-1:0] addr_q;
  logic [15:0]                        remaining_q;
  logic                               req_q;
  logic [31:0]                        data_q;

  function automatic logic [7:0] rotl_byte(input logic [7:0] b);
    return {b[6:0], b[7]};
  endfunction

  // Key mixing per byte, then a rotation of the whole word
  function automatic logic [31:0] encipher(input logic [31:0] plain_word,
                                           input aes_data_pkg::aes_word_u key);
    aes_data_pkg::aes_word_u plain;
    aes_data_pkg::aes_word_u mixed;
    plain.word     = plain_word;
    mixed.bytes.b3 = rotl_byte(plain.bytes.b3 ^ key.bytes.b3);
    mixed.bytes.b2 = rotl_byte(plain.bytes.b2 ^ key.bytes.b2);
    mixed.bytes.b1 = rotl_byte(plain.bytes.b1 ^ key.bytes.b1);
    mixed.bytes.b0 = rotl_byte(plain.bytes.b0 ^ key.bytes.b0);
    return (mixed.word << aes_data_pkg::WORD_ROTATE) |
           (mixed.word >> (32 - aes_data_pkg::WORD_ROTATE));
  endfunction

  // Pop only with no write pending
  assign pop_o = !req_q && !fifo_empty_i && (remaining_q != '0);

  always_ff @(posedge clk) begin
    if (pop_o) begin
      data_q <= encipher(pop_data_i, key_i);
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      addr_q      <= '0;
      remaining_q <= '0;
      req_q       <= 1'b0;
    end else if (job_start_i) begin
      addr_q      <= base_i;
      remaining_q <= length_i;
      req_q       <= 1'b0;
    end else if (req_q && wr_gnt_i) begin
      req_q       <= 1'b0;
      addr_q      <= addr_q + aes_cfg_pkg::ADDR_WIDTH'(4);
      remaining_q <= remaining_q - 16'd1;
    end else if (pop_o) begin
      req_q <= 1'b1;
    end
  end

  assign wr_req_o  = req_q;
  assign wr_addr_o = addr_q;
  assign wr_data_o = data_q;
  // Pending write is still counted in remaining_q
  assign done_o    = (remaining_q == '0);

  a_wr_stable: assert property (@(posedge clk) disable iff (!reset_n)
    wr_req_o && !wr_gnt_i |=> wr_req_o && $stable(wr_addr_o) && $stable(wr_data_o))
    else $error("write request changed before grant");

endmodule

/* hdl/aes_top.sv */
module aes_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                               clk,
  input  logic                               reset_n,
  input  logic                               psel_i,
  input  logic                               penable_i,
  input  logic                               pwrite_i,
  input  logic [7:0]                         paddr_i,
  input  logic [31:0]                        pwdata_i,
  output logic [31:0]                        prdata_o,
  output logic                               pslverr_o,
  output logic                               rd_req_o,
  output logic [aes_cfg_pkg::ADDR_WIDTH-1:0] rd_addr_o,
  input  logic                               rd_gnt_i,
  input  logic [31:0]                        rd_data_i,
  input  logic                               rd_valid_i,
  output logic                               wr_req_o,
  output logic [aes_cfg_pkg::ADDR_WIDTH-1:0] wr_addr_o,
  output logic [31:0]                        wr_data_o,
  input  logic                               wr_gnt_i
);

  logic                               start;
  logic [aes_cfg_pkg::ADDR_WIDTH-1:0] src_base;
  logic [aes_cfg_pkg::ADDR_WIDTH-1:0] dst_base;
  logic [15:0]                        length;
  aes_data_pkg::aes_word_u            key;
  logic                               busy;
  logic                               done;
  logic                               job_start;
  logic                               src_done;
  logic                               sink_done;
  logic                               fifo_empty;
  logic                               fifo_almost_full;
  logic                               push;
  logic [31:0]                        push_data;
  logic                               pop;
  logic [31:0]                        pop_data;

  aes_regfile i_regfile (
    .clk, .reset_n, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .busy_i(busy), .done_i(done), .prdata_o, .pslverr_o, .start_o(start),
    .src_base_o(src_base), .dst_base_o(dst_base), .length_o(length), .key_o(key)
  );

  aes_fsm i_fsm (
    .clk, .reset_n, .start_i(start), .src_done_i(src_done), .sink_done_i(sink_done),
    .fifo_empty_i(fifo_empty), .job_start_o(job_start), .busy_o(busy), .done_o(done)
  );

  // Source holds back while the FIFO has no room beyond its pending read
  plaintext_source i_source (
    .clk, .reset_n, .job_start_i(job_start), .base_i(src_base), .length_i(length),
    .rd_gnt_i, .rd_data_i, .rd_valid_i, .fifo_full_i(fifo_almost_full),
    .rd_req_o, .rd_addr_o, .push_o(push), .push_data_o(push_data), .done_o(src_done)
  );

  word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_fifo (
    .clk, .reset_n, .clear_i(job_start), .push_i(push), .push_data_i(push_data),
    .pop_i(pop), .pop_data_o(pop_data), .full_o(), .empty_o(fifo_empty),
    .almost_full_o(fifo_almost_full)
  );

  cipher_sink i_sink (
    .clk, .reset_n, .job_start_i(job_start), .base_i(dst_base), .length_i(length),
    .key_i(key), .pop_data_i(pop_data), .fifo_empty_i(fifo_empty), .wr_gnt_i,
    .pop_o(pop), .wr_req_o, .wr_addr_o, .wr_data_o, .done_o(sink_done)
  );

endmodule

/* verification/tb_clock.sv */
module tb_clock (
  output logic clk_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // 40 ns period
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

endmodule

/* verification/aes_tb.sv */
module aes_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          FIFO_DEPTH = 4;
  localparam logic [31:0] MEM_BASE   = 32'h0000_2000;
  localparam logic [31:0] LFSR_SEED  = 32'h5492_7216;

  logic        clk;
  logic        reset_n;
  logic        psel_i;
  logic        penable_i;
  logic        pwrite_i;
  logic [7:0]  paddr_i;
  logic [31:0] pwdata_i;
  logic [31:0] prdata_o;
  logic        pslverr_o;
  logic        rd_req_o;
  logic [31:0] rd_addr_o;
  logic        rd_gnt_i;
  logic [31:0] rd_data_i;
  logic        rd_valid_i;
  logic        wr_req_o;
  logic [31:0] wr_addr_o;
  logic [31:0] wr_data_o;
  logic        wr_gnt_i;

  // Memory model state
  logic [31:0]             mem_plain [64];
  logic                    stall_wr;
  logic [31:0]             cur_src;
  int                      job_rd_base;
  int                      rd_total;
  int                      wr_total;
  logic [31:0]             exp_addr_q [$];
  aes_data_pkg::aes_word_u exp_data_q [$];

  tb_clock i_clock (.clk_o(clk));

  aes_top #(.FIFO_DEPTH(FIFO_DEPTH)) uut (.*);

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  // Two LFSR bits give a delay of 0 to 3 cycles
  task automatic draw_delay(inout logic [31:0] state, output int delay);
    delay = 0;
    for (int k = 0; k < 2; k++) begin
      state = lfsr_step(state);
      delay = delay * 2 + int'(state[0]);
    end
  endtask

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]};
  endfunction

  // Key XOR per byte, byte rotate by one, then word rotate left by 8
  function automatic aes_data_pkg::aes_word_u cipher_ref(input aes_data_pkg::aes_word_u plain,
                                                         input aes_data_pkg::aes_word_u key);
    aes_data_pkg::aes_word_u mixed;
    aes_data_pkg::aes_word_u result;
    logic [7:0]              b;
    for (int i = 0; i < 4; i++) begin
      b = plain.word[8*i +: 8] ^ key.word[8*i +: 8];
      mixed.word[8*i +: 8] = {b[6:0], b[7]};
    end
    result.word = {mixed.bytes.b2, mixed.bytes.b1, mixed.bytes.b0, mixed.bytes.b3};
    return result;
  endfunction

  task automatic fail_with(input string line);
    $display("%s", line);
    $display("Finished with errors");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_word(input aes_data_pkg::aes_word_u got,
                            input aes_data_pkg::aes_word_u exp, input string what);
    if (got.word !== exp.word) begin
      fail_with($sformatf("MISMATCH at %0t: %s got %08h expected %08h",
                          $time, what, got.word, exp.word));
    end
  endtask

  task automatic check_reg(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      fail_with($sformatf("MISMATCH at %0t: %s got %08h expected %08h", $time, what, got, exp));
    end
  endtask

  task automatic check_addr(input logic [aes_cfg_pkg::ADDR_WIDTH-1:0] got,
                            input logic [aes_cfg_pkg::ADDR_WIDTH-1:0] exp, input string what);
    if (got !== exp) begin
      fail_with($sformatf("MISMATCH at %0t: %s got %08h expected %08h", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      fail_with($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  // Setup phase, access phase, then one idle cycle
  task automatic apb_access(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(negedge clk);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = write;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(negedge clk);
    penable_i = 1'b1;
    @(posedge clk);
    rdata = prdata_o;
    err   = pslverr_o;
    @(negedge clk);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b1, addr, data, rdata, err);
    check_flag(err, 1'b0, $sformatf("pslverr on write to %02h", addr));
  endtask

  task automatic read_check(input logic [7:0] addr, input logic [31:0] exp, input string what);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b0, addr, 32'h0, rdata, err);
    check_flag(err, 1'b0, $sformatf("pslverr on read of %02h", addr));
    check_reg(rdata, exp, what);
  endtask

  // Queue the expected writes, program the job and trigger it
  task automatic start_job(input logic [31:0] src, input logic [31:0] dst, input logic [15:0] len,
                           input aes_data_pkg::aes_word_u key);
    aes_data_pkg::aes_word_u plain;
    int                      base_idx;
    base_idx    = int'((src - MEM_BASE) >> 2);
    cur_src     = src;
    job_rd_base = rd_total;
    for (int i = 0; i < int'(len); i++) begin
      plain.word = mem_plain[base_idx + i];
      exp_addr_q.push_back(dst + 32'(4 * i));
      exp_data_q.push_back(cipher_ref(plain, key));
    end
    write_reg(aes_cfg_pkg::REG_SRC, src);
    write_reg(aes_cfg_pkg::REG_DST, dst);
    write_reg(aes_cfg_pkg::REG_LEN, {16'h0000, len});
    write_reg(aes_cfg_pkg::REG_KEY, key.word);
    write_reg(aes_cfg_pkg::REG_CTRL, 32'h1);
  endtask

  task automatic wait_done();
    logic [31:0] status;
    logic        err;
    int          polls;
    polls = 0;
    do begin
      apb_access(1'b0, aes_cfg_pkg::REG_STATUS, 32'h0, status, err);
      polls++;
      if (polls > 200) begin
        fail_with("Timeout: the job never reached the done status");
      end
    end while (!status[aes_cfg_pkg::STATUS_DONE]);
    check_reg(status, 32'd1 << aes_cfg_pkg::STATUS_DONE, "STATUS after job");
    check_reg(32'(wr_total), 32'(exp_data_q.size()), "writes completed at done");
  endtask

  // Read port with one outstanding read and random grant and return delays
  initial begin : read_port
    logic [31:0] lfsr;
    logic [31:0] addr;
    logic [31:0] offset;
    int          delay;
    rd_gnt_i   = 1'b0;
    rd_valid_i = 1'b0;
    rd_data_i  = 32'h0;
    rd_total   = 0;
    lfsr       = LFSR_SEED;
    forever begin
      @(negedge clk);
      if (rd_req_o) begin
        draw_delay(lfsr, delay);
        repeat (delay) @(negedge clk);
        addr = rd_addr_o;
        check_addr(addr, cur_src + 32'(4 * (rd_total - job_rd_base)), "read address");
        rd_gnt_i = 1'b1;
        @(negedge clk);
        rd_gnt_i = 1'b0;
        rd_total++;
        draw_delay(lfsr, delay);
        repeat (delay) @(negedge clk);
        offset = addr - MEM_BASE;
        if (offset >= 32'd256) begin
          fail_with("Read outside the plaintext memory");
        end
        rd_data_i  = mem_plain[offset[7:2]];
        rd_valid_i = 1'b1;
        @(negedge clk);
        rd_valid_i = 1'b0;
      end
    end
  end

  // Write port holding its grant back while stalled
  initial begin : write_port
    logic [31:0] lfsr;
    int          delay;
    wr_gnt_i = 1'b0;
    lfsr     = LFSR_SEED;
    forever begin
      @(negedge clk);
      if (wr_req_o && !stall_wr) begin
        draw_delay(lfsr, delay);
        repeat (delay) @(negedge clk);
        wr_gnt_i = 1'b1;
        @(negedge clk);
        wr_gnt_i = 1'b0;
      end
    end
  end

  // Each granted write against the next expected one
  initial begin : compare_writes
    aes_data_pkg::aes_word_u got;
    wr_total = 0;
    forever begin
      @(posedge clk);
      if (wr_req_o && wr_gnt_i) begin
        if (wr_total >= exp_data_q.size()) begin
          fail_with("Unexpected write on the write port");
        end
        got.word = wr_data_o;
        check_addr(wr_addr_o, exp_addr_q[wr_total], "write address");
        check_word(got, exp_data_q[wr_total], "write data");
        wr_total++;
      end
    end
  end

  initial begin : main_sequence
    aes_data_pkg::aes_word_u key_a;
    aes_data_pkg::aes_word_u key_b;
    logic [31:0]             rdata;
    logic                    err;
    int                      rd_before;
    int                      wr_before;
    int                      polls;
    reset_n     = 1'b0;
    psel_i      = 1'b0;
    penable_i   = 1'b0;
    pwrite_i    = 1'b0;
    paddr_i     = 8'h00;
    pwdata_i    = 32'h0;
    stall_wr    = 1'b0;
    cur_src     = MEM_BASE;
    job_rd_base = 0;
    key_a.word  = 32'h3C5A_96E1;
    key_b.word  = 32'hC1D2_E3F4;
    for (int i = 0; i < 64; i++) begin
      mem_plain[i] = fill_word(MEM_BASE + 32'(4 * i));
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    // Register readback
    write_reg(aes_cfg_pkg::REG_SRC, 32'h0000_2040);
    write_reg(aes_cfg_pkg::REG_DST, 32'h8000_0300);
    write_reg(aes_cfg_pkg::REG_LEN, 32'h0000_0005);
    write_reg(aes_cfg_pkg::REG_KEY, 32'hA5A5_0F0F);
    read_check(aes_cfg_pkg::REG_SRC, 32'h0000_2040, "SRC readback");
    read_check(aes_cfg_pkg::REG_DST, 32'h8000_0300, "DST readback");
    read_check(aes_cfg_pkg::REG_LEN, 32'h0000_0005, "LEN readback");
    read_check(aes_cfg_pkg::REG_KEY, 32'hA5A5_0F0F, "KEY readback");
    read_check(aes_cfg_pkg::REG_STATUS, 32'h0, "STATUS after reset");

    // Eight words without a stall
    start_job(MEM_BASE, 32'h8000_0000, 16'd8, key_a);
    wait_done();
    check_reg(32'(wr_total), 32'd8, "write count after eight-word job");

    // Twelve words with the write port stalled first
    stall_wr  = 1'b1;
    wr_before = wr_total;
    start_job(MEM_BASE + 32'h40, 32'h8000_0100, 16'd12, key_b);
    read_check(aes_cfg_pkg::REG_STATUS, 32'd1 << aes_cfg_pkg::STATUS_BUSY, "STATUS while busy");
    apb_access(1'b1, aes_cfg_pkg::REG_KEY, 32'hFFFF_0000, rdata, err);
    check_flag(err, 1'b1, "pslverr on KEY write while busy");
    read_check(aes_cfg_pkg::REG_KEY, key_b.word, "KEY after refused write");

    // Full FIFO plus the word held in the sink
    polls = 0;
    while (rd_total - job_rd_base < FIFO_DEPTH + 1) begin
      @(negedge clk);
      polls++;
      if (polls > 200) begin
        fail_with("Timeout: the source never filled the FIFO while writes were stalled");
      end
    end
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      if (rd_total - job_rd_base > FIFO_DEPTH + 1) begin
        fail_with("Source kept reading while the FIFO was full");
      end
    end
    check_reg(32'(wr_total), 32'(wr_before), "writes while stalled");
    stall_wr = 1'b0;
    wait_done();
    check_reg(32'(wr_total), 32'd20, "write count after twelve-word job");

    // Empty job touches no memory
    rd_before = rd_total;
    wr_before = wr_total;
    start_job(MEM_BASE, 32'h8000_0200, 16'd0, key_a);
    wait_done();
    check_reg(32'(rd_total - rd_before), 32'd0, "reads in empty job");
    check_reg(32'(wr_total - wr_before), 32'd0, "writes in empty job");

    // Unmapped offset
    apb_access(1'b0, 8'h1C, 32'h0, rdata, err);
    check_flag(err, 1'b1, "pslverr on read of 1C");
    apb_access(1'b1, 8'h1C, 32'h1234_5678, rdata, err);
    check_flag(err, 1'b1, "pslverr on write of 1C");

    $display("Finished with no errors");
    $finish;
  end

endmodule

/* sources.f */
hdl/aes_cfg_pkg.sv
hdl/aes_data_pkg.sv
hdl/aes_regfile.sv
hdl/aes_fsm.sv
hdl/plaintext_source.sv
hdl/word_fifo.sv
hdl/cipher_sink.sv
hdl/aes_top.sv
verification/tb_clock.sv
verification/aes_tb.sv

/* run.sh */
#!/bin/sh
# Compile with Verilator and run the testbench from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module aes_tb -f sources.f --Mdir obj_dir -o aes_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

output=$(./obj_dir/aes_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
  exit 0
fi
exit 1
